// ==== source/picobus_pkg.sv ====
// picobus peripheral shared types
`default_nettype none

package picobus_pkg;

    // ------------------------------
    // bus bundles
    // ------------------------------

    // cpu to peripheral, same packing as the packed mem bus
    // wdata [68:37], wstrb [36:33], addr [32:1], valid [0]
    typedef struct packed {
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic [31:0] addr;
        logic        valid;
    } bus_fwd_t;

    // peripheral back to cpu
    // ready [32] above rdata [31:0]
    typedef struct packed {
        logic        ready;
        logic [31:0] rdata;
    } bus_ret_t;

    // ------------------------------
    // register map and sequencing
    // ------------------------------

    // register opcode, taken from addr[3:2] of a word access
    typedef enum logic [1:0] {
        reg_scratch = 2'd0,
        reg_control = 2'd1,
        reg_accum   = 2'd2,
        reg_ident   = 2'd3
    } sfr_reg_e;

    // access sequencer shared by the blocks and the unmapped responder
    // idle waits for select, busy spends the fixed wait cycle,
    // done is the single ready cycle
    typedef enum logic [1:0] {
        acc_idle = 2'd0,
        acc_busy = 2'd1,
        acc_done = 2'd2
    } access_state_e;

    // ------------------------------
    // cluster constants
    // ------------------------------

    // read value for an address that no block claims
    localparam logic [31:0] unmapped_rdata = 32'hbad0_add0;

    // number of register blocks on the bus, sets the select width
    localparam int num_blocks = 2;

endpackage

`default_nettype wire

// ==== source/mem_addr_decode.sv ====
// bus address decoder
`default_nettype none

module mem_addr_decode (
    input  logic                               clk,
    input  logic                               rst,
    input  picobus_pkg::bus_fwd_t              bus_fwd,
    input  logic [7:0]                         base_addr  [picobus_pkg::num_blocks],
    input  logic [7:0]                         base2_addr [picobus_pkg::num_blocks],
    output logic [picobus_pkg::num_blocks-1:0] sel,
    output logic                               unmapped
);

    // edges from select to the edge where the master samples ready
    localparam logic [1:0] ready_age = 2'd2;

    logic [picobus_pkg::num_blocks-1:0] hit;
    // set once the current transfer has been decoded
    logic                               taken;
    // counts edges since the select was registered
    logic [1:0]                         age;

    // ------------------------------
    // address match
    // ------------------------------

    // addr[31:14] against base byte, second base byte and two zero bits
    always_comb begin
        for (int i = 0; i < picobus_pkg::num_blocks; i++) begin
            hit[i] = bus_fwd.addr[31:14] == {base_addr[i], base2_addr[i], 2'b00};
        end
    end

    // ------------------------------
    // registered select
    // ------------------------------

    // decode once per transfer, on the first edge valid is seen
    // ready comes back a fixed two edges after the select, so the
    // select drops on the edge where the master samples ready
    always_ff @(posedge clk) begin
        if (rst) begin
            sel      <= '0;
            unmapped <= 1'b0;
            taken    <= 1'b0;
            age      <= 2'd0;
        end else if (!bus_fwd.valid) begin
            // no transfer on the bus, re-arm for the next one
            sel      <= '0;
            unmapped <= 1'b0;
            taken    <= 1'b0;
            age      <= 2'd0;
        end else if (!taken) begin
            sel      <= hit;
            unmapped <= ~|hit;
            taken    <= 1'b1;
            age      <= 2'd0;
        end else if (age == ready_age) begin
            // transfer complete, hold cleared until valid drops
            sel      <= '0;
            unmapped <= 1'b0;
        end else begin
            age <= age + 2'd1;
        end
    end

    // overlapping bases from the top would select two blocks at once
    a_sel_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(sel))
        else $error("decoder selected more than one block: %b", sel);

    // a select never outlives the request that caused it
    a_sel_needs_valid: assert property (@(posedge clk) disable iff (rst)
        (|sel || unmapped) |-> bus_fwd.valid)
        else $error("select or unmapped flag high without valid");

endmodule

`default_nettype wire

// ==== source/bus_rule_check.sv ====
// valid/ready bus rule checker
`default_nettype none

module bus_rule_check #(
    parameter logic [31:0] max_stall_cycles = 32'd3
) (
    input logic                  clk,
    input logic                  rst,
    input picobus_pkg::bus_fwd_t bus_fwd,
    input picobus_pkg::bus_ret_t bus_ret,
    input logic                  sel
);

    // cycles this block has been selected without answering
    logic [31:0] stall_count;
    // request fields that must hold while waiting
    logic [67:0] req;

    assign req = {bus_fwd.addr, bus_fwd.wstrb, bus_fwd.wdata};

    // ------------------------------
    // stall counter
    // ------------------------------

    // the bus stalls normally while another block is addressed,
    // so only selected cycles count
    always_ff @(posedge clk) begin
        if (rst) begin
            stall_count <= '0;
        end else if (sel && bus_fwd.valid && !bus_ret.ready) begin
            stall_count <= stall_count + 32'd1;
        end else begin
            stall_count <= '0;
        end
    end

    a_stall_bound: assert property (@(posedge clk) disable iff (rst)
        stall_count <= max_stall_cycles)
        else $error("stall count %0d above bound %0d", stall_count, max_stall_cycles);

    // ------------------------------
    // peripheral side rules
    // ------------------------------

    // cannot answer a request that is not there
    a_ready_needs_valid: assert property (@(posedge clk) disable iff (rst)
        bus_ret.ready |-> bus_fwd.valid)
        else $error("ready without valid");

    // rdata is quiet outside the ready cycle
    a_rdata_quiet: assert property (@(posedge clk) disable iff (rst)
        !bus_ret.ready |-> bus_ret.rdata == 32'h0)
        else $error("rdata %h without ready", bus_ret.rdata);

    // ready is a single cycle pulse
    a_ready_pulse: assert property (@(posedge clk) disable iff (rst)
        bus_ret.ready |=> !bus_ret.ready)
        else $error("ready held longer than one cycle");

    // decoder select must come before the answer
    a_ready_after_sel: assert property (@(posedge clk) disable iff (rst)
        bus_ret.ready |-> $past(sel))
        else $error("ready without an earlier select");

    // ------------------------------
    // master side rules
    // ------------------------------

    // a waiting request keeps valid and every field stable
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        sel && bus_fwd.valid && !bus_ret.ready |=> bus_fwd.valid && $stable(req))
        else $error("request changed before ready");

endmodule

`default_nettype wire

// ==== source/sfr_block.sv ====
// special function register block
`default_nettype none

module sfr_block #(
    parameter logic [7:0]  base_addr        = 8'h00,
    parameter logic [7:0]  base2_addr       = 8'h00,
    parameter logic [31:0] max_stall_cycles = 32'd3
) (
    input  logic                  clk,
    input  logic                  rst,
    input  picobus_pkg::bus_fwd_t bus_fwd,
    input  logic                  sel,
    output picobus_pkg::bus_ret_t bus_ret
);

    picobus_pkg::access_state_e state;
    picobus_pkg::sfr_reg_e      reg_sel;

    // register file
    logic [31:0] scratch;
    logic [7:0]  control;
    logic [31:0] accum;
    logic [31:0] ident;

    // request decode
    logic [31:0] byte_mask;
    logic [31:0] wdata_masked;
    logic [31:0] read_value;
    logic        is_write;

    // return bundle registers
    logic        ready_q;
    logic [31:0] rdata_q;

    // ------------------------------
    // request decode
    // ------------------------------

    // word registers, opcode from addr[3:2]
    assign reg_sel  = picobus_pkg::sfr_reg_e'(bus_fwd.addr[3:2]);
    assign is_write = |bus_fwd.wstrb;

    // ident mirrors the two base bytes in its low half
    assign ident = {16'h0000, base_addr, base2_addr};

    // expand byte strobes to a bit mask
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            byte_mask[8*b +: 8] = {8{bus_fwd.wstrb[b]}};
        end
    end

    assign wdata_masked = bus_fwd.wdata & byte_mask;

    // read mux, control is zero extended
    always_comb begin
        case (reg_sel)
            picobus_pkg::reg_scratch: read_value = scratch;
            picobus_pkg::reg_control: read_value = {24'h000000, control};
            picobus_pkg::reg_accum:   read_value = accum;
            default:                  read_value = ident;
        endcase
    end

    // ------------------------------
    // access sequencer
    // ------------------------------

    // idle -> busy on select, busy -> done raises ready, done -> idle
    // read data is captured with ready and zero in every other cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= picobus_pkg::acc_idle;
            ready_q <= 1'b0;
            rdata_q <= '0;
        end else begin
            case (state)
                picobus_pkg::acc_idle: begin
                    ready_q <= 1'b0;
                    rdata_q <= '0;
                    if (sel) begin
                        state <= picobus_pkg::acc_busy;
                    end
                end
                picobus_pkg::acc_busy: begin
                    state   <= picobus_pkg::acc_done;
                    ready_q <= 1'b1;
                    // writes answer with zero
                    rdata_q <= is_write ? 32'h0 : read_value;
                end
                default: begin
                    // done, or an illegal encoding
                    state   <= picobus_pkg::acc_idle;
                    ready_q <= 1'b0;
                    rdata_q <= '0;
                end
            endcase
        end
    end

    // ------------------------------
    // register writes
    // ------------------------------

    // applied on the edge that raises ready
    always_ff @(posedge clk) begin
        if (rst) begin
            scratch <= '0;
            control <= '0;
            accum   <= '0;
        end else if (state == picobus_pkg::acc_busy && is_write) begin
            case (reg_sel)
                picobus_pkg::reg_scratch: begin
                    scratch <= (scratch & ~byte_mask) | wdata_masked;
                end
                picobus_pkg::reg_control: begin
                    // only the low byte is kept
                    if (bus_fwd.wstrb[0]) begin
                        control <= bus_fwd.wdata[7:0];
                    end
                end
                picobus_pkg::reg_accum: begin
                    // control bit 0 picks xor over add
                    if (control[0]) begin
                        accum <= accum ^ wdata_masked;
                    end else begin
                        accum <= accum + wdata_masked;
                    end
                end
                default: begin
                    // ident is read only
                end
            endcase
        end
    end

    assign bus_ret.ready = ready_q;
    assign bus_ret.rdata = rdata_q;

    // bus rules seen from this block
    bus_rule_check #(
        .max_stall_cycles(max_stall_cycles)
    ) u_rule_check (
        .clk    (clk),
        .rst    (rst),
        .bus_fwd(bus_fwd),
        .bus_ret(bus_ret),
        .sel    (sel)
    );

endmodule

`default_nettype wire

// ==== source/ret_merge.sv ====
// return bundle merger
`default_nettype none

module ret_merge (
    input  logic                  clk,
    input  logic                  rst,
    input  picobus_pkg::bus_ret_t blk_ret [picobus_pkg::num_blocks],
    input  logic                  unmapped,
    output picobus_pkg::bus_ret_t bus_ret
);

    // unmapped responder sequencer
    picobus_pkg::access_state_e state;
    logic                       u_ready;
    logic [31:0]                u_rdata;
    // one bit per ready source, the responder on top
    logic [picobus_pkg::num_blocks:0] rdy_vec;

    // ------------------------------
    // unmapped responder
    // ------------------------------

    // same pace as a block so both paths answer after two cycles
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= picobus_pkg::acc_idle;
        end else begin
            case (state)
                picobus_pkg::acc_idle: begin
                    if (unmapped) begin
                        state <= picobus_pkg::acc_busy;
                    end
                end
                picobus_pkg::acc_busy: state <= picobus_pkg::acc_done;
                default:               state <= picobus_pkg::acc_idle;
            endcase
        end
    end

    // master ignores rdata on writes, so no strobe check here
    assign u_ready = state == picobus_pkg::acc_done;
    assign u_rdata = u_ready ? picobus_pkg::unmapped_rdata : 32'h0;

    // ------------------------------
    // merge
    // ------------------------------

    // idle sources return all zero, so a plain or is enough
    always_comb begin
        bus_ret.ready = u_ready;
        bus_ret.rdata = u_rdata;
        rdy_vec[picobus_pkg::num_blocks] = u_ready;
        for (int i = 0; i < picobus_pkg::num_blocks; i++) begin
            bus_ret.ready = bus_ret.ready | blk_ret[i].ready;
            bus_ret.rdata = bus_ret.rdata | blk_ret[i].rdata;
            rdy_vec[i]    = blk_ret[i].ready;
        end
    end

    a_single_source: assert property (@(posedge clk) disable iff (rst)
        $onehot0(rdy_vec))
        else $error("more than one ready source: %b", rdy_vec);

endmodule

`default_nettype wire

// ==== source/picobus_periph_top.sv ====
// picobus peripheral cluster top
`default_nettype none

module picobus_periph_top #(
    parameter logic [7:0]  base_addr0       = 8'h00,
    parameter logic [7:0]  base2_addr0      = 8'h00,
    parameter logic [7:0]  base_addr1       = 8'h00,
    parameter logic [7:0]  base2_addr1      = 8'h04,
    parameter logic [31:0] max_stall_cycles = 32'd3
) (
    input  logic                  clk,
    input  logic                  rst,
    input  picobus_pkg::bus_fwd_t bus_fwd,
    output picobus_pkg::bus_ret_t bus_ret
);

    // base bytes per block for the decoder
    logic [7:0] dec_base  [picobus_pkg::num_blocks];
    logic [7:0] dec_base2 [picobus_pkg::num_blocks];

    // decode to execute and result
    logic [picobus_pkg::num_blocks-1:0] sel;
    logic                               unmapped;

    // per block return bundles
    picobus_pkg::bus_ret_t blk_ret [picobus_pkg::num_blocks];

    assign dec_base  = '{base_addr0, base_addr1};
    assign dec_base2 = '{base2_addr0, base2_addr1};

    // ------------------------------
    // decode
    // ------------------------------

    mem_addr_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .bus_fwd   (bus_fwd),
        .base_addr (dec_base),
        .base2_addr(dec_base2),
        .sel       (sel),
        .unmapped  (unmapped)
    );

    // ------------------------------
    // register blocks
    // ------------------------------

    sfr_block #(
        .base_addr       (base_addr0),
        .base2_addr      (base2_addr0),
        .max_stall_cycles(max_stall_cycles)
    ) u_sfr0 (
        .clk    (clk),
        .rst    (rst),
        .bus_fwd(bus_fwd),
        .sel    (sel[0]),
        .bus_ret(blk_ret[0])
    );

    sfr_block #(
        .base_addr       (base_addr1),
        .base2_addr      (base2_addr1),
        .max_stall_cycles(max_stall_cycles)
    ) u_sfr1 (
        .clk    (clk),
        .rst    (rst),
        .bus_fwd(bus_fwd),
        .sel    (sel[1]),
        .bus_ret(blk_ret[1])
    );

    // ------------------------------
    // result
    // ------------------------------

    ret_merge u_merge (
        .clk     (clk),
        .rst     (rst),
        .blk_ret (blk_ret),
        .unmapped(unmapped),
        .bus_ret (bus_ret)
    );

endmodule

`default_nettype wire

// ==== verification/picobus_model.svh ====
// register cluster reference model
`ifndef picobus_model_svh
`define picobus_model_svh

// ------------------------------
// random source
// ------------------------------

localparam logic [31:0] lfsr_seed = 32'h47cc;
// x^32 + x^22 + x^2 + x + 1, right shifting form
localparam logic [31:0] lfsr_taps = 32'h8020_0003;

logic [31:0] lfsr_state;

// one galois step
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
        n = n ^ lfsr_taps;
    end
    return n;
endfunction

// one step per bit taken, bits land lsb last
function automatic logic [31:0] rand_bits(input int width);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < width; i++) begin
        v = {v[30:0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
endfunction

// ------------------------------
// register state of both blocks
// ------------------------------

logic [31:0] m_scratch [2];
logic [7:0]  m_control [2];
logic [31:0] m_accum   [2];

function automatic void model_reset();
    for (int i = 0; i < 2; i++) begin
        m_scratch[i] = '0;
        m_control[i] = '0;
        m_accum[i]   = '0;
    end
endfunction

// block index from addr[31:14], -1 when no window matches
function automatic int model_block(input logic [31:0] addr);
    if (addr[31:14] == {base_addr0, base2_addr0, 2'b00}) begin
        return 0;
    end
    if (addr[31:14] == {base_addr1, base2_addr1, 2'b00}) begin
        return 1;
    end
    return -1;
endfunction

function automatic logic [31:0] strobe_mask(input logic [3:0] wstrb);
    logic [31:0] m;
    for (int b = 0; b < 4; b++) begin
        m[8*b +: 8] = {8{wstrb[b]}};
    end
    return m;
endfunction

// writes to an unmapped address leave every register alone
function automatic void model_write(input logic [31:0] addr, input logic [31:0] wdata,
                                    input logic [3:0] wstrb);
    int          blk;
    logic [31:0] mask;
    blk  = model_block(addr);
    mask = strobe_mask(wstrb);
    if (blk >= 0) begin
        case (picobus_pkg::sfr_reg_e'(addr[3:2]))
            picobus_pkg::reg_scratch: begin
                m_scratch[blk] = (m_scratch[blk] & ~mask) | (wdata & mask);
            end
            picobus_pkg::reg_control: begin
                // only byte lane 0 exists
                if (wstrb[0]) begin
                    m_control[blk] = wdata[7:0];
                end
            end
            picobus_pkg::reg_accum: begin
                if (m_control[blk][0]) begin
                    m_accum[blk] = m_accum[blk] ^ (wdata & mask);
                end else begin
                    m_accum[blk] = m_accum[blk] + (wdata & mask);
                end
            end
            default: begin
                // ident is read only
            end
        endcase
    end
endfunction

function automatic logic [31:0] model_read(input logic [31:0] addr);
    int blk;
    blk = model_block(addr);
    if (blk < 0) begin
        return picobus_pkg::unmapped_rdata;
    end
    case (picobus_pkg::sfr_reg_e'(addr[3:2]))
        picobus_pkg::reg_scratch: return m_scratch[blk];
        picobus_pkg::reg_control: return {24'h000000, m_control[blk]};
        picobus_pkg::reg_accum:   return m_accum[blk];
        default: begin
            // ident shows the two base bytes
            if (blk == 0) begin
                return {16'h0000, base_addr0, base2_addr0};
            end
            return {16'h0000, base_addr1, base2_addr1};
        end
    endcase
endfunction

`endif

// ==== verification/picobus_periph_tb.sv ====
// picobus peripheral cluster testbench
`default_nettype none

module picobus_periph_tb;

    // ------------------------------
    // run constants
    // ------------------------------

    localparam logic [7:0] base_addr0  = 8'h00;
    localparam logic [7:0] base2_addr0 = 8'h00;
    localparam logic [7:0] base_addr1  = 8'h00;
    localparam logic [7:0] base2_addr1 = 8'h04;

    localparam int reset_cycles = 8;
    // edges from the edge that first samples valid to the ready edge
    localparam int ready_latency = 2;
    // drive edge, three waits, drop edge, one spare
    localparam int cycles_per_transfer = 6;
    // reset 8, scratch/control 32, accumulate 36, interleave 48, unmapped 16
    localparam int planned_transfers = 140;
    localparam int cycle_limit = planned_transfers * cycles_per_transfer + reset_cycles + 64;
    // a single transfer gives up long before the run limit
    localparam int ready_wait_limit = 8;

    logic                  clk;
    logic                  rst;
    picobus_pkg::bus_fwd_t bus_fwd;
    picobus_pkg::bus_ret_t bus_ret;

    int error_count;
    int check_count;
    int timing_errors;
    int timing_checks;
    int transfer_count;
    int cycle_count;

    `include "picobus_model.svh"

    picobus_periph_top #(
        .base_addr0      (base_addr0),
        .base2_addr0     (base2_addr0),
        .base_addr1      (base_addr1),
        .base2_addr1     (base2_addr1),
        .max_stall_cycles(32'd3)
    ) dut0 (
        .clk    (clk),
        .rst    (rst),
        .bus_fwd(bus_fwd),
        .bus_ret(bus_ret)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // run limit from the planned transfer count
    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run stopped after %0d cycles before the tests finished", cycle_count);
        $display("Verification failed");
        $finish;
    end

    // ------------------------------
    // checks
    // ------------------------------

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_cond(input logic ok, input string what);
        check_count++;
        assert (ok) else begin
            error_count++;
            $display("at %0t: %s", $time, what);
        end
    endtask

    task automatic report_test(input string name, input int errors_before,
                               input int checks_before);
        if (error_count == errors_before) begin
            $display("test %s: ok, %0d checks", name, check_count - checks_before);
        end else begin
            $display("test %s: %0d of %0d checks wrong", name,
                     error_count - errors_before, check_count - checks_before);
        end
    endtask

    // ------------------------------
    // bus driver
    // ------------------------------

    // one transfer driven on falling edges with its handshake checks counted apart
    task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] wstrb, output logic [31:0] rdata);
        int   waited;
        int   errors_before;
        int   checks_before;
        logic seen;
        errors_before = error_count;
        checks_before = check_count;
        waited = 0;
        seen = 1'b0;
        rdata = '0;
        @(negedge clk);
        // the idle bus before a transfer carries no answer
        check_value("bus_ret.ready", 32'(bus_ret.ready), 32'h0);
        check_value("bus_ret.rdata", bus_ret.rdata, 32'h0);
        bus_fwd.wdata = wdata;
        bus_fwd.wstrb = wstrb;
        bus_fwd.addr  = addr;
        bus_fwd.valid = 1'b1;
        transfer_count++;
        while (!seen && waited < ready_wait_limit) begin
            @(negedge clk);
            waited++;
            if (bus_ret.ready) begin
                seen = 1'b1;
                rdata = bus_ret.rdata;
            end else begin
                check_value("bus_ret.rdata", bus_ret.rdata, 32'h0);
            end
        end
        check_cond(seen, "no ready while valid was held");
        // first waited edge is the one that samples valid
        check_value("ready latency", 32'(waited - 1), 32'(ready_latency));
        // valid stays over the ready edge and ready must be gone by then
        @(negedge clk);
        check_value("bus_ret.ready", 32'(bus_ret.ready), 32'h0);
        check_value("bus_ret.rdata", bus_ret.rdata, 32'h0);
        bus_fwd = '0;
        timing_errors += error_count - errors_before;
        timing_checks += check_count - checks_before;
    endtask

    task automatic read_check(input logic [31:0] addr);
        logic [31:0] rd;
        bus_access(addr, 32'h0, 4'h0, rd);
        check_value("bus_ret.rdata", rd, model_read(addr));
    endtask

    task automatic write_op(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb);
        logic [31:0] rd;
        bus_access(addr, wdata, wstrb, rd);
        model_write(addr, wdata, wstrb);
    endtask

    // ------------------------------
    // stimulus helpers
    // ------------------------------

    // random word offset inside the block window with the opcode in [3:2]
    function automatic logic [31:0] reg_addr(input int blk, input logic [1:0] r);
        logic [15:0] base;
        logic [31:0] offs;
        base = (blk == 0) ? {base_addr0, base2_addr0} : {base_addr1, base2_addr1};
        offs = rand_bits(10);
        return {base, 2'b00, offs[9:0], r, 2'b00};
    endfunction

    function automatic logic [31:0] unmapped_addr();
        logic [31:0] a;
        a = rand_bits(32);
        a[1:0] = 2'b00;
        // both windows sit under a zero top byte
        if (model_block(a) >= 0) begin
            a[31] = 1'b1;
        end
        return a;
    endfunction

    // zero strobes would turn the write into a read
    function automatic logic [3:0] nonzero_strobe();
        logic [31:0] s;
        s = rand_bits(4);
        return (s[3:0] == 4'h0) ? 4'hf : s[3:0];
    endfunction

    task automatic read_all_regs();
        for (int blk = 0; blk < 2; blk++) begin
            for (int r = 0; r < 4; r++) begin
                read_check(reg_addr(blk, r[1:0]));
            end
        end
    endtask

    // ------------------------------
    // tests
    // ------------------------------

    task automatic test_reset_state();
        repeat (3) begin
            @(negedge clk);
            check_value("bus_ret.ready", 32'(bus_ret.ready), 32'h0);
            check_value("bus_ret.rdata", bus_ret.rdata, 32'h0);
        end
        read_all_regs();
    endtask

    task automatic test_scratch_control();
        logic [31:0] blk;
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        repeat (16) begin
            blk   = rand_bits(1);
            r     = rand_bits(1);
            addr  = reg_addr(int'(blk[0]), r[1:0]);
            wdata = rand_bits(32);
            wstrb = nonzero_strobe();
            write_op(addr, wdata, wstrb);
            read_check(addr);
        end
    endtask

    // add mode first, then xor mode
    task automatic test_accumulate();
        logic [31:0] blk;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        for (int mode = 0; mode < 2; mode++) begin
            for (int b = 0; b < 2; b++) begin
                addr     = reg_addr(b, picobus_pkg::reg_control);
                wdata    = rand_bits(32);
                wdata[0] = mode[0];
                write_op(addr, wdata, 4'hf);
            end
            repeat (8) begin
                blk   = rand_bits(1);
                addr  = reg_addr(int'(blk[0]), picobus_pkg::reg_accum);
                wdata = rand_bits(32);
                wstrb = nonzero_strobe();
                write_op(addr, wdata, wstrb);
                read_check(addr);
            end
        end
    endtask

    task automatic test_interleave();
        logic [31:0] blk;
        logic [31:0] r;
        logic [31:0] is_wr;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        repeat (40) begin
            blk   = rand_bits(1);
            r     = rand_bits(2);
            is_wr = rand_bits(1);
            addr  = reg_addr(int'(blk[0]), r[1:0]);
            if (is_wr[0]) begin
                wdata = rand_bits(32);
                wstrb = nonzero_strobe();
                write_op(addr, wdata, wstrb);
            end else begin
                read_check(addr);
            end
        end
        read_all_regs();
    endtask

    // even steps read, odd steps write
    task automatic test_unmapped();
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        for (int i = 0; i < 8; i++) begin
            addr = unmapped_addr();
            if (i % 2 == 0) begin
                read_check(addr);
            end else begin
                wdata = rand_bits(32);
                wstrb = nonzero_strobe();
                write_op(addr, wdata, wstrb);
            end
        end
        read_all_regs();
    endtask

    // ------------------------------
    // sequence
    // ------------------------------

    initial begin
        int e0;
        int c0;
        rst = 1'b1;
        bus_fwd = '0;
        error_count = 0;
        check_count = 0;
        timing_errors = 0;
        timing_checks = 0;
        transfer_count = 0;
        lfsr_state = lfsr_seed;
        model_reset();
        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;

        e0 = error_count;
        c0 = check_count;
        test_reset_state();
        report_test("reset_state", e0, c0);
        e0 = error_count;
        c0 = check_count;
        test_scratch_control();
        report_test("scratch_control", e0, c0);
        e0 = error_count;
        c0 = check_count;
        test_accumulate();
        report_test("accumulate", e0, c0);
        e0 = error_count;
        c0 = check_count;
        test_interleave();
        report_test("interleave", e0, c0);
        e0 = error_count;
        c0 = check_count;
        test_unmapped();
        report_test("unmapped", e0, c0);
        // handshake timing was checked inside every transfer above
        report_test("handshake_timing", error_count - timing_errors,
                    check_count - timing_checks);

        $display("summary: %0d transfers, %0d checks, %0d errors",
                 transfer_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== picobus_periph.f ====
+incdir+verification
source/picobus_pkg.sv
source/mem_addr_decode.sv
source/bus_rule_check.sv
source/sfr_block.sv
source/ret_merge.sv
source/picobus_periph_top.sv
verification/picobus_periph_tb.sv
